// ==== verilog/ice51_pkg.sv ====
package ice51_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [9:0]  code_addr_t;    // program memory is 1k bytes
   typedef logic [15:0] dptr_t;
   typedef logic [2:0]  reg_idx_t;      // r0 .. r7

   //////////////////////////////////////////////////////////////////////
   // opcode map

   localparam byte_t OP_LJMP         = 8'h02;
   localparam byte_t OP_INC_A        = 8'h04;
   localparam byte_t OP_RRC          = 8'h13;
   localparam byte_t OP_DEC_A        = 8'h14;
   localparam byte_t OP_RL           = 8'h23;
   localparam byte_t OP_ADD_A_IMM    = 8'h24;
   localparam byte_t OP_RLC          = 8'h33;
   localparam byte_t OP_ADDC_A_IMM   = 8'h34;
   localparam byte_t OP_JC           = 8'h40;
   localparam byte_t OP_ORL_A_IMM    = 8'h44;
   localparam byte_t OP_JNC          = 8'h50;
   localparam byte_t OP_ANL_A_IMM    = 8'h54;
   localparam byte_t OP_JZ           = 8'h60;
   localparam byte_t OP_XRL_A_IMM    = 8'h64;
   localparam byte_t OP_JNZ          = 8'h70;
   localparam byte_t OP_MOV_A_IMM    = 8'h74;
   localparam byte_t OP_SJMP         = 8'h80;
   localparam byte_t OP_MOV_DPTR     = 8'h90;   // high byte first
   localparam byte_t OP_SUBB_A_IMM   = 8'h94;
   localparam byte_t OP_CLR_C        = 8'hC3;
   localparam byte_t OP_SWAP         = 8'hC4;
   localparam byte_t OP_SETB_C       = 8'hD3;
   localparam byte_t OP_MOVX_A_DPTR  = 8'hE0;
   localparam byte_t OP_CLR_A        = 8'hE4;
   localparam byte_t OP_MOVX_DPTR_A  = 8'hF0;
   localparam byte_t OP_CPL_A        = 8'hF4;

   // register groups, low three bits select rn
   localparam byte_t OP_INC_R        = 8'h08;
   localparam byte_t OP_DEC_R        = 8'h18;
   localparam byte_t OP_ADD_A_R      = 8'h28;
   localparam byte_t OP_MOV_R_IMM    = 8'h78;
   localparam byte_t OP_DJNZ_R       = 8'hD8;
   localparam byte_t OP_MOV_A_R      = 8'hE8;
   localparam byte_t OP_MOV_R_A      = 8'hF8;

   // movx targets
   localparam dptr_t IO_TX_STATUS    = 16'h0200;
   localparam dptr_t IO_TX_DATA      = 16'h0201;

   //////////////////////////////////////////////////////////////////////
   // control types

   typedef enum logic [4:0] {
      ALU_MOVE, ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_INC, ALU_DEC, ALU_CLR, ALU_CPL, ALU_RL, ALU_RLC, ALU_RRC, ALU_SWAP,
      ALU_SETC, ALU_CLRC, ALU_NONE
   } alu_op_e;

   typedef enum logic [1:0] {SRC_IMM, SRC_REG, SRC_IO} a_src_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_SJMP, BR_JZ, BR_JNZ, BR_JC, BR_JNC, BR_DJNZ, BR_LJMP
   } br_e;

   typedef enum logic [2:0] {FS_REQ, FS_OPCODE, FS_OPER1, FS_OPER2, FS_EXEC} fetch_state_e;

   typedef struct packed {
      byte_t      opcode;
      byte_t      op1;
      byte_t      op2;
      code_addr_t next_pc;     // fall-through address
   } instr_t;

   typedef struct packed {
      logic [1:0] len;         // bytes incl. opcode
      alu_op_e    alu_op;
      a_src_e     a_src;
      logic       acc_we;
      logic       reg_we;
      reg_idx_t   reg_idx;
      logic       carry_we;
      br_e        br;
      logic       dptr_ld;
      logic       io_wr;
      logic       io_rd;
   } dec_t;

endpackage

// ==== verilog/ice51_fetch.sv ====
`timescale 1ns/1ps

module ice51_fetch import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  byte_t      i_code_dat,
   input  logic       i_code_ack,
   input  dec_t       i_dec,
   input  logic       i_exec_done,
   input  code_addr_t i_pc_next,
   output logic       o_code_cyc,
   output logic       o_code_stb,
   output code_addr_t o_code_adr,
   output byte_t      o_opcode,
   output instr_t     o_instr,
   output dec_t       o_dec,
   output logic       o_instr_valid
);

fetch_state_e state;
code_addr_t   pc;
byte_t        opcode_q;
byte_t        op1_q;
byte_t        op2_q;
dec_t         dec_q;
logic         cyc_q;
logic         take;

assign take       = cyc_q & i_code_ack;   // byte lands this edge
assign o_code_cyc = cyc_q;
assign o_code_stb = cyc_q;

// opcode goes straight to the decoder on its ack so the length is known in time
assign o_opcode = (state == FS_OPCODE) ? i_code_dat : opcode_q;
assign o_dec    = dec_q;
assign o_instr  = '{opcode: opcode_q, op1: op1_q, op2: op2_q,
                    next_pc: pc + code_addr_t'(dec_q.len)};

//////////////////////////////////////////////////////////////////////
// fetch sequencing

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      state         <= FS_REQ;
      pc            <= '0;
      cyc_q         <= 1'b0;
      o_code_adr    <= '0;
      dec_q         <= '0;
      o_instr_valid <= 1'b0;
   end else begin
      o_instr_valid <= 1'b0;
      case (state)
         FS_REQ: begin
            o_code_adr <= pc;
            cyc_q      <= 1'b1;
            state      <= FS_OPCODE;
         end
         FS_OPCODE: begin
            if (take) begin
               cyc_q      <= 1'b0;
               o_code_adr <= o_code_adr + code_addr_t'(1);
               dec_q      <= i_dec;
               if (i_dec.len == 2'd1) begin
                  o_instr_valid <= 1'b1;
                  state         <= FS_EXEC;
               end else begin
                  state <= FS_OPER1;
               end
            end
         end
         FS_OPER1, FS_OPER2: begin
            if (!cyc_q) begin
               cyc_q <= 1'b1;              // idle cycle between reads done
            end else if (i_code_ack) begin
               cyc_q      <= 1'b0;
               o_code_adr <= o_code_adr + code_addr_t'(1);
               if (state == FS_OPER1 && dec_q.len == 2'd3) begin
                  state <= FS_OPER2;
               end else begin
                  o_instr_valid <= 1'b1;
                  state         <= FS_EXEC;
               end
            end
         end
         FS_EXEC: begin
            if (i_exec_done) begin
               pc    <= i_pc_next;
               state <= FS_REQ;
            end
         end
         default: state <= FS_REQ;
      endcase
   end
end

// instruction bytes
always_ff @(posedge i_clk) begin
   if (take) begin
      case (state)
         FS_OPCODE: opcode_q <= i_code_dat;
         FS_OPER1:  op1_q    <= i_code_dat;
         FS_OPER2:  op2_q    <= i_code_dat;
         default:   op2_q    <= op2_q;
      endcase
   end
end

endmodule

// ==== verilog/ice51_decode.sv ====
`timescale 1ns/1ps

module ice51_decode import ice51_pkg::*; (
   input  byte_t i_opcode,
   output dec_t  o_dec
);

always_comb begin
   o_dec         = '0;
   o_dec.alu_op  = ALU_NONE;       // anything unknown runs as a one byte nop
   o_dec.a_src   = SRC_IMM;
   o_dec.br      = BR_NONE;
   o_dec.reg_idx = i_opcode[2:0];

   case (i_opcode)
      OP_MOV_A_IMM:   o_dec.alu_op = ALU_MOVE;
      OP_ADD_A_IMM:   o_dec.alu_op = ALU_ADD;
      OP_ADDC_A_IMM:  o_dec.alu_op = ALU_ADDC;
      OP_SUBB_A_IMM:  o_dec.alu_op = ALU_SUBB;
      OP_ANL_A_IMM:   o_dec.alu_op = ALU_AND;
      OP_ORL_A_IMM:   o_dec.alu_op = ALU_OR;
      OP_XRL_A_IMM:   o_dec.alu_op = ALU_XOR;
      OP_INC_A:       o_dec.alu_op = ALU_INC;
      OP_DEC_A:       o_dec.alu_op = ALU_DEC;
      OP_CLR_A:       o_dec.alu_op = ALU_CLR;
      OP_CPL_A:       o_dec.alu_op = ALU_CPL;
      OP_RL:          o_dec.alu_op = ALU_RL;
      OP_RLC:         o_dec.alu_op = ALU_RLC;
      OP_RRC:         o_dec.alu_op = ALU_RRC;
      OP_SWAP:        o_dec.alu_op = ALU_SWAP;
      OP_SETB_C:      o_dec.alu_op = ALU_SETC;
      OP_CLR_C:       o_dec.alu_op = ALU_CLRC;
      OP_SJMP:        o_dec.br     = BR_SJMP;
      OP_JZ:          o_dec.br     = BR_JZ;
      OP_JNZ:         o_dec.br     = BR_JNZ;
      OP_JC:          o_dec.br     = BR_JC;
      OP_JNC:         o_dec.br     = BR_JNC;
      OP_LJMP:        o_dec.br     = BR_LJMP;
      OP_MOVX_A_DPTR: begin
         o_dec.alu_op = ALU_MOVE;
         o_dec.a_src  = SRC_IO;
      end
      default: begin
         // rn groups, matched on the upper five bits
         case (i_opcode[7:3])
            OP_MOV_R_IMM[7:3]: begin
               o_dec.alu_op = ALU_MOVE;
               o_dec.reg_we = 1'b1;
            end
            OP_MOV_R_A[7:3]:   o_dec.reg_we = 1'b1;   // alu passes acc
            OP_MOV_A_R[7:3]: begin
               o_dec.alu_op = ALU_MOVE;
               o_dec.a_src  = SRC_REG;
            end
            OP_ADD_A_R[7:3]: begin
               o_dec.alu_op = ALU_ADD;
               o_dec.a_src  = SRC_REG;
            end
            OP_INC_R[7:3]: begin
               o_dec.alu_op = ALU_INC;
               o_dec.reg_we = 1'b1;
            end
            OP_DEC_R[7:3]: begin
               o_dec.alu_op = ALU_DEC;
               o_dec.reg_we = 1'b1;
            end
            OP_DJNZ_R[7:3]: begin
               o_dec.alu_op = ALU_DEC;
               o_dec.reg_we = 1'b1;
               o_dec.br     = BR_DJNZ;
            end
            default: o_dec.reg_we = 1'b0;
         endcase
      end
   endcase

   o_dec.dptr_ld  = (i_opcode == OP_MOV_DPTR);
   o_dec.io_wr    = (i_opcode == OP_MOVX_DPTR_A);
   o_dec.io_rd    = (i_opcode == OP_MOVX_A_DPTR);
   o_dec.carry_we = o_dec.alu_op inside {ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_RLC, ALU_RRC,
                                         ALU_SETC, ALU_CLRC};
   o_dec.acc_we   = !o_dec.reg_we && !(o_dec.alu_op inside {ALU_NONE, ALU_SETC, ALU_CLRC});

   // a two-operand op on an immediate carries one byte, as do the relative branches
   if (o_dec.br == BR_LJMP || o_dec.dptr_ld)
      o_dec.len = 2'd3;
   else if (o_dec.br != BR_NONE ||
            (o_dec.a_src == SRC_IMM && o_dec.alu_op inside {[ALU_MOVE:ALU_XOR]}))
      o_dec.len = 2'd2;
   else
      o_dec.len = 2'd1;
end

endmodule

// ==== verilog/ice51_execute.sv ====
`timescale 1ns/1ps

module ice51_execute import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  instr_t     i_instr,
   input  dec_t       i_dec,
   input  logic       i_instr_valid,
   input  logic       i_tx_busy,
   output logic       o_exec_done,
   output code_addr_t o_pc_next,
   output logic       o_tx_start,
   output byte_t      o_tx_data
);

byte_t      acc;
logic       carry;
byte_t      regs [8];
dptr_t      dptr;
byte_t      reg_rd;
byte_t      io_rd_data;
byte_t      alu_a;
byte_t      alu_b;
byte_t      alu_res;
logic       alu_cy;
logic [8:0] sum;
logic [8:0] diff;
byte_t      rel;
code_addr_t br_target;
logic       taken;
logic       tx_wr;
logic       wr_pend;      // tx write waiting on a busy line

assign reg_rd     = regs[i_dec.reg_idx];
assign io_rd_data = (i_dec.io_rd && dptr == IO_TX_STATUS) ? {7'd0, i_tx_busy} : 8'h00;

// inc/dec rn work on the register, everything else on acc
assign alu_a = (i_dec.reg_we && i_dec.alu_op inside {ALU_INC, ALU_DEC}) ? reg_rd : acc;
assign alu_b = (i_dec.a_src == SRC_REG) ? reg_rd :
               (i_dec.a_src == SRC_IO)  ? io_rd_data :
                                          i_instr.op1;

//////////////////////////////////////////////////////////////////////
// alu

always_comb begin
   sum     = {1'b0, alu_a} + {1'b0, alu_b} + {8'd0, carry & (i_dec.alu_op == ALU_ADDC)};
   diff    = {1'b0, alu_a} - {1'b0, alu_b} - {8'd0, carry};   // bit 8 is the borrow
   alu_res = alu_a;
   alu_cy  = carry;
   case (i_dec.alu_op)
      ALU_MOVE:          alu_res = alu_b;
      ALU_ADD, ALU_ADDC: {alu_cy, alu_res} = sum;
      ALU_SUBB:          {alu_cy, alu_res} = diff;
      ALU_AND:           alu_res = alu_a & alu_b;
      ALU_OR:            alu_res = alu_a | alu_b;
      ALU_XOR:           alu_res = alu_a ^ alu_b;
      ALU_INC:           alu_res = alu_a + 8'd1;    // carry untouched
      ALU_DEC:           alu_res = alu_a - 8'd1;
      ALU_CLR:           alu_res = 8'h00;
      ALU_CPL:           alu_res = ~alu_a;
      ALU_RL:            alu_res = {alu_a[6:0], alu_a[7]};
      ALU_RLC:           {alu_cy, alu_res} = {alu_a, carry};
      ALU_RRC:           {alu_res, alu_cy} = {carry, alu_a};
      ALU_SWAP:          alu_res = {alu_a[3:0], alu_a[7:4]};
      ALU_SETC:          alu_cy  = 1'b1;
      ALU_CLRC:          alu_cy  = 1'b0;
      default:           alu_res = alu_a;           // none passes acc through
   endcase
end

//////////////////////////////////////////////////////////////////////
// branches

always_comb begin
   case (i_dec.br)
      BR_SJMP, BR_LJMP: taken = 1'b1;
      BR_JZ:            taken = (acc == 8'h00);
      BR_JNZ:           taken = (acc != 8'h00);
      BR_JC:            taken = carry;
      BR_JNC:           taken = !carry;
      BR_DJNZ:          taken = (alu_res != 8'h00);  // decremented rn
      default:          taken = 1'b0;
   endcase
end

assign rel       = (i_dec.br == BR_DJNZ) ? i_instr.op2 : i_instr.op1;
assign br_target = (i_dec.br == BR_LJMP) ? {i_instr.op1[1:0], i_instr.op2} :
                                           i_instr.next_pc + {{2{rel[7]}}, rel};
assign o_pc_next = taken ? br_target : i_instr.next_pc;

//////////////////////////////////////////////////////////////////////
// architectural state

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      acc   <= '0;
      carry <= 1'b0;
      dptr  <= '0;
      for (int i = 0; i < 8; i++) regs[i] <= '0;
   end else if (i_instr_valid) begin
      if (i_dec.acc_we)   acc                 <= alu_res;
      if (i_dec.carry_we) carry               <= alu_cy;
      if (i_dec.reg_we)   regs[i_dec.reg_idx] <= alu_res;
      if (i_dec.dptr_ld)  dptr                <= {i_instr.op1, i_instr.op2};
   end
end

// serial data write, held off while the transmitter is busy
assign tx_wr = i_dec.io_wr && (dptr == IO_TX_DATA);

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst)                                   wr_pend <= 1'b0;
   else if (i_instr_valid && tx_wr && i_tx_busy)  wr_pend <= 1'b1;
   else if (!i_tx_busy)                           wr_pend <= 1'b0;
end

assign o_tx_start  = tx_wr && (i_instr_valid || wr_pend) && !i_tx_busy;
assign o_tx_data   = acc;
assign o_exec_done = (i_instr_valid && !(tx_wr && i_tx_busy)) || (wr_pend && !i_tx_busy);

endmodule

// ==== verilog/ice51_uart_tx.sv ====
`timescale 1ns/1ps

module ice51_uart_tx import ice51_pkg::*; #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_start,
   input  byte_t i_data,
   output logic  o_tx,
   output logic  o_busy
);

localparam int CW = $clog2(CLKS_PER_BIT);

typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

tx_state_e     state;
logic [CW-1:0] clk_cnt;     // clocks into current bit
logic [2:0]    bit_cnt;
byte_t         shreg;
logic          bit_end;

assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
assign o_busy  = (state != TX_IDLE);

always_comb begin
   case (state)
      TX_START: o_tx = 1'b0;
      TX_DATA:  o_tx = shreg[0];    // lsb first
      default:  o_tx = 1'b1;        // idle and stop bit
   endcase
end

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
   end else begin
      clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
      case (state)
         TX_IDLE:  if (i_start) state <= TX_START;
         TX_START: if (bit_end) begin
            state   <= TX_DATA;
            bit_cnt <= '0;
         end
         TX_DATA:  if (bit_end) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= TX_STOP;
         end
         default:  if (bit_end) state <= TX_IDLE;
      endcase
   end
end

always_ff @(posedge i_clk) begin
   if (state == TX_IDLE && i_start)  shreg <= i_data;
   else if (state == TX_DATA && bit_end) shreg <= {1'b1, shreg[7:1]};
end

endmodule

// ==== verilog/ice51_top.sv ====
`timescale 1ns/1ps

module ice51_top import ice51_pkg::*; #(
   parameter int CLKS_PER_BIT = 104      // serial bit time in clocks
) (
   input  logic       i_clk,
   input  logic       i_nrst,
   output logic       o_code_cyc,
   output logic       o_code_stb,
   output code_addr_t o_code_adr,
   input  byte_t      i_code_dat,
   input  logic       i_code_ack,
   output logic       o_uart_tx
);

byte_t      opcode;
dec_t       dec_comb;     // decoder output
dec_t       dec_q;        // held with the instruction
instr_t     instr;
logic       instr_valid;
logic       exec_done;
code_addr_t pc_next;
logic       tx_start;
byte_t      tx_data;
logic       tx_busy;

//////////////////////////////////////////////////////////////////////
// core

ice51_fetch fetch0 (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_code_dat    (i_code_dat),
   .i_code_ack    (i_code_ack),
   .i_dec         (dec_comb),
   .i_exec_done   (exec_done),
   .i_pc_next     (pc_next),
   .o_code_cyc    (o_code_cyc),
   .o_code_stb    (o_code_stb),
   .o_code_adr    (o_code_adr),
   .o_opcode      (opcode),
   .o_instr       (instr),
   .o_dec         (dec_q),
   .o_instr_valid (instr_valid)
);

ice51_decode decode0 (
   .i_opcode (opcode),
   .o_dec    (dec_comb)
);

ice51_execute execute0 (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_instr       (instr),
   .i_dec         (dec_q),
   .i_instr_valid (instr_valid),
   .i_tx_busy     (tx_busy),
   .o_exec_done   (exec_done),
   .o_pc_next     (pc_next),
   .o_tx_start    (tx_start),
   .o_tx_data     (tx_data)
);

// serial out
ice51_uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx0 (
   .i_clk   (i_clk),
   .i_nrst  (i_nrst),
   .i_start (tx_start),
   .i_data  (tx_data),
   .o_tx    (o_uart_tx),
   .o_busy  (tx_busy)
);

endmodule

// ==== bench/ice51_tb_prog.svh ====
// code memory image and the bytes the program must send
byte_t code_mem [1024];

// executed instructions, loops included, rounded up
localparam int INSTR_BOUND = 300;

// main run from address 0: tests 1 to 3 and the start of test 4
byte_t seg_main [$] = '{
   8'h90, 8'h02, 8'h01,                               // mov dptr,#0201
   8'h74, 8'h5A, 8'hF0, 8'h24, 8'h23, 8'hF0,          // mov, add
   8'h54, 8'h0F, 8'hF0, 8'h44, 8'h30, 8'hF0,          // anl, orl
   8'h64, 8'hFF, 8'hF0, 8'h04, 8'hF0,                 // xrl, inc
   8'h14, 8'h14, 8'hF0, 8'hC4, 8'hF0,                 // dec twice, swap
   8'hF4, 8'hF0, 8'hE4, 8'hF0,                        // cpl, clr
   8'h74, 8'hF0, 8'h24, 8'h20, 8'hF0,                 // f0+20 sets c
   8'h34, 8'h05, 8'hF0,                               // addc
   8'h74, 8'h10, 8'h94, 8'h20, 8'hF0,                 // subb with borrow
   8'h94, 8'h01, 8'hF0,                               // subb eats the borrow
   8'hD3, 8'h74, 8'h00, 8'h33, 8'hF0,                 // setb c, rlc
   8'hD3, 8'h74, 8'h80, 8'h13, 8'hF0,                 // setb c, rrc
   8'h74, 8'h81, 8'h13, 8'hC3, 8'h33, 8'hF0,          // rrc, clr c, rlc
   8'h74, 8'h81, 8'h23, 8'hF0,                        // rl
   8'h78, 8'h11, 8'h79, 8'h22, 8'h74, 8'h33, 8'hFA,   // r0, r1, r2 loads
   8'h08, 8'h19,                                      // inc r0, dec r1
   8'hE8, 8'hF0, 8'hE9, 8'hF0, 8'hEA, 8'hF0,
   8'h74, 8'h01, 8'h29, 8'hF0,                        // add a,r1
   8'h7F, 8'hFF, 8'h0F, 8'hEF, 8'hF0,                 // r7 wraps to 0
   8'h7B, 8'h05, 8'h02, 8'h01, 8'hF4                  // r3 = 5, ljmp 1f4
};

// at 1f4: djnz takes its offset from operand two, left there by the ljmp before it
byte_t seg_loop [$] = '{
   8'hEB, 8'hF0, 8'h02, 8'h01, 8'hF9, 8'hDB, 8'h00,
   8'h60, 8'h03, 8'h74, 8'hA1, 8'hF0,                 // jz not taken
   8'hE4, 8'h60, 8'h03, 8'h74, 8'hEE, 8'hF0, 8'h74, 8'hA2, 8'hF0,
   8'h70, 8'h03, 8'h74, 8'hEE, 8'hF0, 8'h74, 8'hA3, 8'hF0,
   8'hE4, 8'h70, 8'h03, 8'h74, 8'hA4, 8'hF0,          // jnz not taken
   8'hD3, 8'h40, 8'h03, 8'h74, 8'hEE, 8'hF0, 8'h74, 8'hA5, 8'hF0,
   8'h50, 8'h03, 8'h74, 8'hA6, 8'hF0,                 // jnc not taken
   8'hC3, 8'h50, 8'h03, 8'h74, 8'hEE, 8'hF0, 8'h74, 8'hA7, 8'hF0,
   8'h40, 8'h03, 8'h74, 8'hA8, 8'hF0,                 // jc not taken
   8'h80, 8'h05, 8'h74, 8'hB2, 8'hF0, 8'h80, 8'h05,   // b2 block reached backward
   8'h74, 8'hB1, 8'hF0, 8'h80, 8'hF6,
   8'h74, 8'hC1, 8'hF0, 8'h74, 8'hC2, 8'hF0,          // writes without polling
   8'h74, 8'hC3, 8'hF0, 8'h74, 8'hC4, 8'hF0,
   8'h90, 8'h02, 8'h00, 8'hE0, 8'h90, 8'h02, 8'h01, 8'hF0,
   8'h90, 8'h02, 8'h00, 8'h7F, 8'h28, 8'h02, 8'h02, 8'hF8
};

// at 2f8: delay loop of 40 passes, then the idle status and a halt
byte_t seg_delay [$] = '{
   8'h02, 8'h02, 8'hFB, 8'hDF, 8'h00,
   8'hE0, 8'h90, 8'h02, 8'h01, 8'hF0, 8'h80, 8'hFE
};

byte_t exp_bytes [$] = '{
   8'h5A, 8'h7D, 8'h0D, 8'h3D, 8'hC2, 8'hC3, 8'hC1, 8'h1C, 8'hE3, 8'h00,
   8'h10, 8'h16, 8'hF0, 8'hEE, 8'h01, 8'hC0, 8'h80, 8'h03,
   8'h12, 8'h21, 8'h33, 8'h22, 8'h00,
   8'h05, 8'h04, 8'h03, 8'h02, 8'h01, 8'hA1, 8'hA2, 8'hA3, 8'hA4,
   8'hA5, 8'hA6, 8'hA7, 8'hA8, 8'hB1, 8'hB2,
   8'hC1, 8'hC2, 8'hC3, 8'hC4, 8'h01, 8'h00
};

// index of the last byte of each test
int    test_last [$] = '{9, 17, 22, 37, 43};
string test_name [$] = '{"immediate ops", "carry and rotate", "registers",
                         "branches", "tx back-pressure and status"};

task automatic place(input int base, input byte_t seg [$]);
   foreach (seg[i]) code_mem[base + i] = seg[i];
endtask

task automatic load_program();
   for (int a = 0; a < 1024; a++) code_mem[a] = byte_t'(a ^ (a >> 2) ^ 8'hC5);
   place(0, seg_main);
   place(10'h1F4, seg_loop);
   place(10'h2F8, seg_delay);
endtask

// ==== bench/ice51_tb.sv ====
`timescale 1ns/1ps

module ice51_tb import ice51_pkg::*; ();

localparam int BIT_CLKS    = 8;
localparam int FETCH_WORST = 17;   // three reads of idle plus four waits, exec and one spare

logic       i_clk;
logic       i_nrst;
logic       code_cyc;
logic       code_stb;
code_addr_t code_adr;
byte_t      code_dat = 8'h00;
logic       code_ack = 1'b0;
logic       uart_tx;

`include "ice51_tb_prog.svh"

logic [31:0] lfsr;
int          errors;
int          bus_errors;
int          rx_count;
int          cycles;
int          limit;
int          test_idx;
int          test_err_base;
bit          rd_wait;
int          ack_wait;
logic        prev_stb;
code_addr_t  prev_adr;

ice51_top #(.CLKS_PER_BIT(BIT_CLKS)) dut0 (
   .i_clk      (i_clk),
   .i_nrst     (i_nrst),
   .o_code_cyc (code_cyc),
   .o_code_stb (code_stb),
   .o_code_adr (code_adr),
   .i_code_dat (code_dat),
   .i_code_ack (code_ack),
   .o_uart_tx  (uart_tx)
);

initial begin
   i_clk = 1'b0;
   forever #4 i_clk = ~i_clk;
end

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
endfunction

//////////////////////////////////////////////////////////////////////
// code memory, 0 to 3 wait cycles per read

always @(negedge i_clk) begin
   if (!i_nrst) begin
      code_ack <= 1'b0;
      rd_wait = 1'b0;
   end else if (code_ack) begin
      code_ack <= 1'b0;                   // one ack per read
   end else if (code_cyc && code_stb) begin
      if (!rd_wait) begin
         rd_wait = 1'b1;
         ack_wait = 0;
         repeat (2) begin
            lfsr = lfsr_step(lfsr);
            ack_wait = ack_wait * 2 + int'(lfsr[0]);
         end
      end
      if (ack_wait == 0) begin
         code_ack <= 1'b1;
         code_dat <= code_mem[code_adr];
         rd_wait = 1'b0;
      end else begin
         ack_wait--;
      end
   end
end

//////////////////////////////////////////////////////////////////////
// bus and line rules

always @(negedge i_clk) begin
   if (!i_nrst) begin
      assert (uart_tx === 1'b1 && code_cyc === 1'b0 && code_stb === 1'b0) else begin
         $display("at %0t: serial line not idle or bus active during reset", $time);
         bus_errors++;
      end
      prev_stb = 1'b0;
   end else begin
      assert (!(code_stb && !code_cyc)) else begin
         $display("at %0t: o_code_stb high without o_code_cyc", $time);
         bus_errors++;
      end
      if (prev_stb && !code_ack) begin   // read still open
         assert (code_stb) else begin
            $display("at %0t: o_code_stb dropped before ack", $time);
            bus_errors++;
         end
         assert (code_adr == prev_adr) else begin
            $display("MISMATCH at %0t: o_code_adr expected %h got %h", $time, prev_adr,
                     code_adr);
            bus_errors++;
         end
      end
      prev_stb = code_stb;
      prev_adr = code_adr;
   end
end

//////////////////////////////////////////////////////////////////////
// serial receiver

task automatic check_byte(input byte_t got);
   if (rx_count >= exp_bytes.size()) begin
      $display("at %0t: unexpected extra byte %h on o_uart_tx", $time, got);
      errors++;
   end else begin
      assert (got == exp_bytes[rx_count]) else begin
         $display("MISMATCH at %0t: o_uart_tx byte %0d expected %h got %h", $time, rx_count,
                  exp_bytes[rx_count], got);
         errors++;
      end
      if (test_idx < test_last.size() && rx_count == test_last[test_idx]) begin
         $display("test %0d %s: %s (%0d errors)", test_idx + 1, test_name[test_idx],
                  (errors == test_err_base) ? "pass" : "fail", errors - test_err_base);
         test_idx++;
         test_err_base = errors;
      end
   end
   rx_count++;
endtask

always begin
   byte_t rx;
   @(negedge i_clk);
   if (i_nrst && uart_tx === 1'b0) begin
      repeat (BIT_CLKS / 2 - 1) @(negedge i_clk);   // middle of start bit
      assert (uart_tx === 1'b0) else begin
         $display("at %0t: start bit too short on o_uart_tx", $time);
         errors++;
      end
      for (int b = 0; b < 8; b++) begin
         repeat (BIT_CLKS) @(negedge i_clk);
         rx[b] = uart_tx;                            // lsb first
      end
      repeat (BIT_CLKS) @(negedge i_clk);
      assert (uart_tx === 1'b1) else begin
         $display("at %0t: stop bit low on o_uart_tx", $time);
         errors++;
      end
      check_byte(rx);
   end
end

//////////////////////////////////////////////////////////////////////
// main sequence

initial begin
   i_nrst        = 1'b0;
   lfsr          = 32'h431d;
   errors        = 0;
   bus_errors    = 0;
   rx_count      = 0;
   cycles        = 0;
   test_idx      = 0;
   test_err_base = 0;
   load_program();
   limit = 2 * (exp_bytes.size() * 10 * BIT_CLKS + INSTR_BOUND * FETCH_WORST);
   repeat (10) @(negedge i_clk);
   i_nrst = 1'b1;
   while (rx_count < exp_bytes.size() && cycles < limit) begin
      @(negedge i_clk);
      cycles++;
   end
   if (rx_count < exp_bytes.size()) begin
      $display("timeout after %0d cycles with %0d of %0d bytes received", cycles, rx_count,
               exp_bytes.size());
      $display("ERRORS FOUND");
   end else begin
      repeat (20 * BIT_CLKS) @(negedge i_clk);   // room for stray frames
      $display("test 6 bus and line rules: %s (%0d errors)",
               (bus_errors == 0) ? "pass" : "fail", bus_errors);
      $display("bytes %0d of %0d, byte errors %0d, bus errors %0d", rx_count,
               exp_bytes.size(), errors, bus_errors);
      if (errors == 0 && bus_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
   end
   $finish;
end

endmodule

// ==== ice51_top.f ====
+incdir+bench
verilog/ice51_pkg.sv
verilog/ice51_fetch.sv
verilog/ice51_decode.sv
verilog/ice51_execute.sv
verilog/ice51_uart_tx.sv
verilog/ice51_top.sv
bench/ice51_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ice51_tb
RTL_TOP    := ice51_top
FILELIST   := ice51_top.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
